/* hdl/pa_pkg.sv */
/*
	Shared types for the P-A arithmetic pipeline.
	Words are numbered with bit 0 as the most significant bit.
	Modules refer to these definitions by scoped names.
*/

package pa_pkg;

	// data word, bit 0 is the MSB
	typedef logic [0:15] pa_word_t;

	// result flags in order zero, sign, carry, overflow
	typedef logic [0:3] pa_flags_t;

	// ALU function select
	typedef enum logic [3:0] {
		op_pass_a  = 4'd0,
		op_pass_ac = 4'd1,
		op_add     = 4'd2,
		op_sub     = 4'd3,
		op_and     = 4'd4,
		op_or      = 4'd5,
		op_xor     = 4'd6,
		op_inc     = 4'd7,
		op_dec     = 4'd8
	} pa_op_t;

	// A operand select
	typedef enum logic [1:0] {
		src_lit = 2'd0,
		src_ic  = 2'd1,
		src_ar  = 2'd2,
		src_at  = 2'd3
	} pa_src_t;

	// write-back destination
	typedef enum logic [2:0] {
		dst_none = 3'd0,
		dst_ac   = 3'd1,
		dst_ar   = 3'd2,
		dst_ic   = 3'd3,
		dst_at   = 3'd4
	} pa_dst_t;

	// true when the function takes AC as its B operand
	function automatic logic uses_ac(input pa_op_t op);
		logic reads;
		case (op)
			op_pass_a,
			op_inc,
			op_dec:  reads = 1'b0;
			default: reads = 1'b1;
		endcase
		return reads;
	endfunction

endpackage

/* hdl/pa_stage_if.sv */
/*
	Handshaked link between two pipeline stages.
	The sender uses the up modport, the receiver the down modport.
	A beat moves on a clock edge with valid and ready both high.
*/

interface pa_stage_if;

	logic valid;
	logic ready;

	pa_pkg::pa_op_t   op;
	pa_pkg::pa_dst_t  dst;
	pa_pkg::pa_word_t lit;

	// operand words, reused for result payload on the last link
	pa_pkg::pa_word_t opa;
	pa_pkg::pa_word_t opb;

	modport up (
		output valid,
		output op,
		output dst,
		output lit,
		output opa,
		output opb,
		input  ready
	);

	modport down (
		input  valid,
		input  op,
		input  dst,
		input  lit,
		input  opa,
		input  opb,
		output ready
	);

endinterface

/* hdl/pa_regs.sv */
/*
	Architectural registers AC, AR, IC and AT.
	One write port from the result stage, reads are combinational.
	All four registers clear on reset.
*/

module pa_regs (
	input  logic              clk,
	input  logic              rst,
	input  logic              wr_en,
	input  pa_pkg::pa_dst_t   wr_dst,
	input  pa_pkg::pa_word_t  wr_data,
	output pa_pkg::pa_word_t  ac,
	output pa_pkg::pa_word_t  ar,
	output pa_pkg::pa_word_t  ic,
	output pa_pkg::pa_word_t  at
);

	pa_pkg::pa_word_t reg_ac;
	pa_pkg::pa_word_t reg_ar;
	pa_pkg::pa_word_t reg_ic;
	pa_pkg::pa_word_t reg_at;

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_ac <= '0;
			reg_ar <= '0;
			reg_ic <= '0;
			reg_at <= '0;
		end else if (wr_en) begin
			case (wr_dst)
				pa_pkg::dst_ac: reg_ac <= wr_data;
				pa_pkg::dst_ar: reg_ar <= wr_data;
				pa_pkg::dst_ic: reg_ic <= wr_data;
				pa_pkg::dst_at: reg_at <= wr_data;
				default: ;
			endcase
		end
	end

	assign ac = reg_ac;
	assign ar = reg_ar;
	assign ic = reg_ic;
	assign at = reg_at;

	// result stage only raises a write for a real destination
	a_wr_dst: assert property (
		@(posedge clk) disable iff (rst)
		wr_en |-> wr_dst != pa_pkg::dst_none
	);

endmodule

/* hdl/pa_fetch.sv */
/*
	Input stage of the pipeline.
	Holds one micro-operation, reads its operands from the register block
	as it moves on, and stalls behind an ALU occupant it depends on.
*/

module pa_fetch (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	output logic              in_ready,
	input  pa_pkg::pa_op_t    in_op,
	input  pa_pkg::pa_src_t   in_src,
	input  pa_pkg::pa_dst_t   in_dst,
	input  pa_pkg::pa_word_t  in_lit,
	input  pa_pkg::pa_word_t  ac,
	input  pa_pkg::pa_word_t  ar,
	input  pa_pkg::pa_word_t  ic,
	input  pa_pkg::pa_word_t  at,
	pa_stage_if.up            fetch_to_alu,
	input  pa_pkg::pa_dst_t   alu_dst,
	input  logic              alu_busy
);

	logic             f_valid;
	pa_pkg::pa_op_t   f_op;
	pa_pkg::pa_src_t  f_src;
	pa_pkg::pa_dst_t  f_dst;
	pa_pkg::pa_word_t f_lit;

	pa_pkg::pa_dst_t  src_reg;
	logic             hazard;
	logic             move;

	// register named by the A source, none for a literal
	always_comb begin
		case (f_src)
			pa_pkg::src_ic: src_reg = pa_pkg::dst_ic;
			pa_pkg::src_ar: src_reg = pa_pkg::dst_ar;
			pa_pkg::src_at: src_reg = pa_pkg::dst_at;
			default:        src_reg = pa_pkg::dst_none;
		endcase
	end

	// ALU occupant writes something we are about to read
	assign hazard = alu_busy && alu_dst != pa_pkg::dst_none &&
		(alu_dst == src_reg ||
		(alu_dst == pa_pkg::dst_ac && pa_pkg::uses_ac(f_op)));

	assign fetch_to_alu.valid = f_valid && !hazard;
	assign fetch_to_alu.op    = f_op;
	assign fetch_to_alu.dst   = f_dst;
	assign fetch_to_alu.lit   = f_lit;
	assign fetch_to_alu.opb   = ac;

	always_comb begin
		case (f_src)
			pa_pkg::src_ic: fetch_to_alu.opa = ic;
			pa_pkg::src_ar: fetch_to_alu.opa = ar;
			pa_pkg::src_at: fetch_to_alu.opa = at;
			default:        fetch_to_alu.opa = f_lit;
		endcase
	end

	assign move     = fetch_to_alu.valid && fetch_to_alu.ready;
	assign in_ready = !rst && (!f_valid || move);

	always_ff @(posedge clk) begin
		if (rst)
			f_valid <= 1'b0;
		else if (in_valid && in_ready)
			f_valid <= 1'b1;
		else if (move)
			f_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			f_op  <= in_op;
			f_src <= in_src;
			f_dst <= in_dst;
			f_lit <= in_lit;
		end
	end

	// a held micro-op must not change under interlock or back-pressure
	a_hold: assert property (
		@(posedge clk) disable iff (rst)
		f_valid && !move |=> f_valid && $stable({f_op, f_src, f_dst, f_lit})
	);

endmodule

/* hdl/pa_alu.sv */
/*
	ALU stage of the pipeline.
	Computes the function of the A operand and AC with one shared adder,
	then registers the result, flags and destination for the output stage.
*/

module pa_alu (
	input  logic             clk,
	input  logic             rst,
	pa_stage_if.down         fetch_to_alu,
	pa_stage_if.up           alu_to_res,
	output pa_pkg::pa_dst_t  alu_dst,
	output logic             alu_busy
);

	logic              a_valid;
	pa_pkg::pa_word_t  a_res;
	pa_pkg::pa_flags_t a_flags;
	pa_pkg::pa_dst_t   a_dst;

	pa_pkg::pa_word_t  opa;
	pa_pkg::pa_word_t  b_eff;
	pa_pkg::pa_word_t  add_b;
	logic              add_cin;
	logic [0:16]       sum;
	pa_pkg::pa_word_t  res;
	logic              carry;
	logic              ovf;
	logic              arith;

	assign opa = fetch_to_alu.opa;

	// inc and dec see zero in place of AC
	assign b_eff   = pa_pkg::uses_ac(fetch_to_alu.op) ? fetch_to_alu.opb : '0;
	assign add_b   = (fetch_to_alu.op == pa_pkg::op_sub ||
		fetch_to_alu.op == pa_pkg::op_dec) ? ~b_eff : b_eff;
	assign add_cin = fetch_to_alu.op == pa_pkg::op_sub ||
		fetch_to_alu.op == pa_pkg::op_inc;
	assign sum     = {1'b0, opa} + {1'b0, add_b} + {16'd0, add_cin};

	always_comb begin
		arith = 1'b0;
		case (fetch_to_alu.op)
			pa_pkg::op_pass_a:  res = opa;
			pa_pkg::op_pass_ac: res = fetch_to_alu.opb;
			pa_pkg::op_and:     res = opa & fetch_to_alu.opb;
			pa_pkg::op_or:      res = opa | fetch_to_alu.opb;
			pa_pkg::op_xor:     res = opa ^ fetch_to_alu.opb;
			default: begin
				res   = sum[1:16];
				arith = 1'b1;
			end
		endcase
	end

	// carry out is the extra top bit, overflow on same-sign inputs
	assign carry = arith && sum[0];
	assign ovf   = arith && (opa[0] == add_b[0]) && (res[0] != opa[0]);

	assign fetch_to_alu.ready = !a_valid || alu_to_res.ready;

	always_ff @(posedge clk) begin
		if (rst)
			a_valid <= 1'b0;
		else if (fetch_to_alu.ready)
			a_valid <= fetch_to_alu.valid;
	end

	always_ff @(posedge clk) begin
		if (fetch_to_alu.valid && fetch_to_alu.ready) begin
			a_res   <= res;
			a_flags <= {res == '0, res[0], carry, ovf};
			a_dst   <= fetch_to_alu.dst;
		end
	end

	// result word travels as the literal, flags in the low bits of opa
	assign alu_to_res.valid = a_valid;
	assign alu_to_res.op    = pa_pkg::op_pass_a;
	assign alu_to_res.dst   = a_dst;
	assign alu_to_res.lit   = a_res;
	assign alu_to_res.opa   = {12'd0, a_flags};
	assign alu_to_res.opb   = '0;

	assign alu_dst  = a_dst;
	assign alu_busy = a_valid;

endmodule

/* hdl/pa_result.sv */
/*
	Output stage of the pipeline.
	Registers the result word, flags and destination toward the consumer
	and writes the destination register as a micro-op enters.
*/

module pa_result (
	input  logic              clk,
	input  logic              rst,
	pa_stage_if.down          alu_to_res,
	output logic              out_valid,
	input  logic              out_ready,
	output pa_pkg::pa_word_t  out_result,
	output pa_pkg::pa_flags_t out_flags,
	output pa_pkg::pa_dst_t   out_dst,
	output logic              wr_en,
	output pa_pkg::pa_dst_t   wr_dst,
	output pa_pkg::pa_word_t  wr_data
);

	logic              r_valid;
	pa_pkg::pa_word_t  r_result;
	pa_pkg::pa_flags_t r_flags;
	pa_pkg::pa_dst_t   r_dst;
	logic              accept;

	assign alu_to_res.ready = !r_valid || out_ready;
	assign accept = alu_to_res.valid && alu_to_res.ready;

	// write lands on the same edge the micro-op moves in
	assign wr_en   = accept && alu_to_res.dst != pa_pkg::dst_none;
	assign wr_dst  = alu_to_res.dst;
	assign wr_data = alu_to_res.lit;

	always_ff @(posedge clk) begin
		if (rst)
			r_valid <= 1'b0;
		else if (alu_to_res.ready)
			r_valid <= alu_to_res.valid;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			r_result <= alu_to_res.lit;
			r_flags  <= alu_to_res.opa[12:15];
			r_dst    <= alu_to_res.dst;
		end
	end

	assign out_valid  = r_valid;
	assign out_result = r_result;
	assign out_flags  = r_flags;
	assign out_dst    = r_dst;

	// a stalled beat keeps its word until the consumer takes it
	a_out_stable: assert property (
		@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_result)
	);

endmodule

/* hdl/pa_top.sv */
/*
	Top level of the P-A arithmetic pipeline.
	Micro-ops enter on the in_ port and results leave on the out_ port,
	both with a valid/ready handshake.
*/

module pa_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	output logic              in_ready,
	input  pa_pkg::pa_op_t    in_op,
	input  pa_pkg::pa_src_t   in_src,
	input  pa_pkg::pa_dst_t   in_dst,
	input  pa_pkg::pa_word_t  in_lit,
	output logic              out_valid,
	input  logic              out_ready,
	output pa_pkg::pa_word_t  out_result,
	output pa_pkg::pa_flags_t out_flags,
	output pa_pkg::pa_dst_t   out_dst
);

	pa_pkg::pa_word_t ac;
	pa_pkg::pa_word_t ar;
	pa_pkg::pa_word_t ic;
	pa_pkg::pa_word_t at;

	logic             wr_en;
	pa_pkg::pa_dst_t  wr_dst;
	pa_pkg::pa_word_t wr_data;

	pa_pkg::pa_dst_t  alu_dst;
	logic             alu_busy;

	pa_stage_if fetch_to_alu ();
	pa_stage_if alu_to_res ();

	pa_regs regs_inst (
		.clk, .rst, .wr_en, .wr_dst, .wr_data,
		.ac, .ar, .ic, .at
	);

	pa_fetch fetch_inst (
		.clk, .rst, .in_valid, .in_ready, .in_op, .in_src, .in_dst, .in_lit,
		.ac, .ar, .ic, .at, .fetch_to_alu, .alu_dst, .alu_busy
	);

	pa_alu alu_inst (
		.clk, .rst, .fetch_to_alu, .alu_to_res, .alu_dst, .alu_busy
	);

	pa_result result_inst (
		.clk, .rst, .alu_to_res, .out_valid, .out_ready,
		.out_result, .out_flags, .out_dst, .wr_en, .wr_dst, .wr_data
	);

endmodule

/* sim/tb_pa_tasks.svh */
/*
	Directed tests for the P-A pipeline, included inside tb_pa.
	Each task starts on a falling edge and ends with finish_test.
*/

// registers read as zero and no result is pending after reset
task automatic zero_after_reset();
	#2;
	if (out_valid !== 1'b0) begin
		$display("out_valid is high right after reset");
		seq_errors++;
	end
	@(negedge clk);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_ic, pa_pkg::dst_none, 16'h1234);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_ar, pa_pkg::dst_none, 16'h1234);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_at, pa_pkg::dst_none, 16'h1234);
	send_op(pa_pkg::op_pass_ac, pa_pkg::src_lit, pa_pkg::dst_none, 16'h1234);
	finish_test("reset");
endtask

task automatic load_registers();
	send_op(pa_pkg::op_pass_a, pa_pkg::src_lit, pa_pkg::dst_ac, 16'hA5C3);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_lit, pa_pkg::dst_ar, 16'h0F1E);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_lit, pa_pkg::dst_ic, 16'h8001);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_lit, pa_pkg::dst_at, 16'h7FFE);
	send_op(pa_pkg::op_pass_ac, pa_pkg::src_lit, pa_pkg::dst_none, 16'h0000);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_ar, pa_pkg::dst_none, 16'h0000);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_ic, pa_pkg::dst_none, 16'h0000);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_at, pa_pkg::dst_none, 16'h0000);
	finish_test("load");
endtask

// sub computes A minus AC
task automatic arith_flags();
	send_op(pa_pkg::op_pass_a, pa_pkg::src_lit, pa_pkg::dst_ac, 16'h0001);
	send_op(pa_pkg::op_add, pa_pkg::src_lit, pa_pkg::dst_none, 16'h7FFF);
	send_op(pa_pkg::op_sub, pa_pkg::src_lit, pa_pkg::dst_none, 16'h0000);
	send_op(pa_pkg::op_add, pa_pkg::src_lit, pa_pkg::dst_none, 16'hFFFF);
	send_op(pa_pkg::op_inc, pa_pkg::src_lit, pa_pkg::dst_ar, 16'h7FFF);
	send_op(pa_pkg::op_dec, pa_pkg::src_lit, pa_pkg::dst_ic, 16'h8000);
	send_op(pa_pkg::op_dec, pa_pkg::src_lit, pa_pkg::dst_none, 16'h0000);
	send_op(pa_pkg::op_sub, pa_pkg::src_ar, pa_pkg::dst_at, 16'h0000);
	finish_test("arith");
endtask

task automatic logic_ops();
	send_op(pa_pkg::op_pass_a, pa_pkg::src_lit, pa_pkg::dst_ac, 16'hF0F0);
	send_op(pa_pkg::op_and, pa_pkg::src_lit, pa_pkg::dst_none, 16'h3C3C);
	send_op(pa_pkg::op_or, pa_pkg::src_lit, pa_pkg::dst_none, 16'h3C3C);
	send_op(pa_pkg::op_xor, pa_pkg::src_lit, pa_pkg::dst_none, 16'hF0F0);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_lit, pa_pkg::dst_ar, 16'h0F0F);
	send_op(pa_pkg::op_xor, pa_pkg::src_ar, pa_pkg::dst_ac, 16'h0000);
	send_op(pa_pkg::op_and, pa_pkg::src_ar, pa_pkg::dst_none, 16'h0000);
	finish_test("logic");
endtask

// each op reads what the one before it wrote
task automatic dependent_chain();
	send_op(pa_pkg::op_pass_a, pa_pkg::src_lit, pa_pkg::dst_ar, 16'h0005);
	send_op(pa_pkg::op_inc, pa_pkg::src_ar, pa_pkg::dst_ar, 16'h0000);
	send_op(pa_pkg::op_inc, pa_pkg::src_ar, pa_pkg::dst_ar, 16'h0000);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_ar, pa_pkg::dst_ac, 16'h0000);
	send_op(pa_pkg::op_add, pa_pkg::src_ar, pa_pkg::dst_ac, 16'h0000);
	send_op(pa_pkg::op_sub, pa_pkg::src_ar, pa_pkg::dst_ic, 16'h0000);
	send_op(pa_pkg::op_dec, pa_pkg::src_ic, pa_pkg::dst_ic, 16'h0000);
	send_op(pa_pkg::op_pass_a, pa_pkg::src_ic, pa_pkg::dst_at, 16'h0000);
	send_op(pa_pkg::op_or, pa_pkg::src_at, pa_pkg::dst_ac, 16'h0000);
	finish_test("chain");
endtask

task automatic random_stream();
	bp_mode = 1'b1;
	repeat (n_random) begin
		send_op(pa_pkg::pa_op_t'(4'($urandom % 9)),
			pa_pkg::pa_src_t'(2'($urandom % 4)),
			pa_pkg::pa_dst_t'(3'($urandom % 5)),
			16'($urandom));
	end
	finish_test("random");
	bp_mode = 1'b0;
endtask

/* sim/tb_pa.sv */
/*
	Testbench for the P-A arithmetic pipeline.
	Drives micro-ops into pa_top, keeps a sequential register model and
	checks every result beat in order. Directed tests are included below.
*/

module tb_pa;

	parameter int n_random = 200;

	// directed micro-ops over all tests
	localparam int period       = 8;
	localparam int n_directed   = 36;
	localparam int limit_cycles = (n_directed + n_random) * 20 + 100;

	logic              clk = 1'b0;
	logic              rst;
	logic              in_valid;
	logic              in_ready;
	pa_pkg::pa_op_t    in_op;
	pa_pkg::pa_src_t   in_src;
	pa_pkg::pa_dst_t   in_dst;
	pa_pkg::pa_word_t  in_lit;
	logic              out_valid;
	logic              out_ready = 1'b1;
	pa_pkg::pa_word_t  out_result;
	pa_pkg::pa_flags_t out_flags;
	pa_pkg::pa_dst_t   out_dst;

	// model registers updated in issue order
	logic [15:0] m_ac;
	logic [15:0] m_ar;
	logic [15:0] m_ic;
	logic [15:0] m_at;

	// expected beats queued by the sequence for the monitor
	logic [15:0]     exp_res[$];
	logic [3:0]      exp_flags[$];
	pa_pkg::pa_dst_t exp_dst[$];

	int   rd_idx = 0;
	int   errors = 0;
	int   seq_errors = 0;
	int   err_mark = 0;
	int   tests_passed = 0;
	int   tests_failed = 0;
	logic bp_mode = 1'b0;

	always #(period / 2) clk = ~clk;

	pa_top pa_top_inst (
		.clk, .rst, .in_valid, .in_ready, .in_op, .in_src, .in_dst, .in_lit,
		.out_valid, .out_ready, .out_result, .out_flags, .out_dst
	);

	// result word followed by the flags zero, sign, carry and overflow
	function automatic logic [19:0] model_alu(input pa_pkg::pa_op_t op,
		input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		logic [15:0] y;
		logic [15:0] r;
		logic        arith;
		logic        c;
		logic        v;
		arith = 1'b1;
		y = 16'h0000;
		s = 17'd0;
		case (op)
			pa_pkg::op_add: begin
				y = b;
				s = {1'b0, a} + {1'b0, y};
			end
			pa_pkg::op_sub: begin
				y = ~b;
				s = {1'b0, a} + {1'b0, y} + 17'd1;
			end
			pa_pkg::op_inc: begin
				y = 16'h0001;
				s = {1'b0, a} + {1'b0, y};
			end
			pa_pkg::op_dec: begin
				y = ~16'h0001;
				s = {1'b0, a} + {1'b0, y} + 17'd1;
			end
			default: arith = 1'b0;
		endcase
		case (op)
			pa_pkg::op_pass_a:  r = a;
			pa_pkg::op_pass_ac: r = b;
			pa_pkg::op_and:     r = a & b;
			pa_pkg::op_or:      r = a | b;
			pa_pkg::op_xor:     r = a ^ b;
			default:            r = s[15:0];
		endcase
		c = arith && s[16];
		v = arith && (a[15] == y[15]) && (r[15] != a[15]);
		return {r, r == 16'h0000, r[15], c, v};
	endfunction

	// starts on a falling edge and returns on the one after the transfer
	task automatic send_op(input pa_pkg::pa_op_t op, input pa_pkg::pa_src_t src,
		input pa_pkg::pa_dst_t dst, input logic [15:0] lit);
		logic [15:0] a;
		logic [19:0] rf;
		logic        taken;
		case (src)
			pa_pkg::src_ic: a = m_ic;
			pa_pkg::src_ar: a = m_ar;
			pa_pkg::src_at: a = m_at;
			default:        a = lit;
		endcase
		rf = model_alu(op, a, m_ac);
		case (dst)
			pa_pkg::dst_ac: m_ac = rf[19:4];
			pa_pkg::dst_ar: m_ar = rf[19:4];
			pa_pkg::dst_ic: m_ic = rf[19:4];
			pa_pkg::dst_at: m_at = rf[19:4];
			default: ;
		endcase
		exp_res.push_back(rf[19:4]);
		exp_flags.push_back(rf[3:0]);
		exp_dst.push_back(dst);
		in_valid = 1'b1;
		in_op    = op;
		in_src   = src;
		in_dst   = dst;
		in_lit   = lit;
		taken    = 1'b0;
		while (!taken) begin
			#2;
			taken = in_ready;
			@(negedge clk);
		end
	endtask

	// drops in_valid and reports the test once all results are in
	task automatic finish_test(input string name);
		int errs;
		in_valid = 1'b0;
		while (rd_idx != exp_res.size())
			@(negedge clk);
		errs = errors + seq_errors - err_mark;
		err_mark = errors + seq_errors;
		if (errs == 0) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: %0d errors", name, errs);
			tests_failed++;
		end
	endtask

	`include "tb_pa_tasks.svh"

	// consumer stalls at random only during the stream test
	always @(negedge clk) begin
		if (bp_mode)
			out_ready = ($urandom % 2) == 0;
		else
			out_ready = 1'b1;
	end

	// result monitor samples mid cycle once outputs have settled
	always @(negedge clk) begin
		#2;
		if (!rst && out_valid && out_ready) begin
			if (rd_idx >= exp_res.size()) begin
				$display("result beat arrived with no micro-op outstanding");
				errors++;
			end else begin
				if (out_result !== exp_res[rd_idx]) begin
					$display("Fail out_result: got %h expected %h (beat %0d)",
						out_result, exp_res[rd_idx], rd_idx);
					errors++;
				end
				if (out_flags !== exp_flags[rd_idx]) begin
					$display("Fail out_flags: got %h expected %h (beat %0d)",
						out_flags, exp_flags[rd_idx], rd_idx);
					errors++;
				end
				if (out_dst !== exp_dst[rd_idx]) begin
					$display("Fail out_dst: got %h expected %h (beat %0d)",
						out_dst, exp_dst[rd_idx], rd_idx);
					errors++;
				end
				rd_idx++;
			end
		end
	end

	initial begin
		#(limit_cycles * period);
		$display("watchdog expired, the pipeline stopped delivering results");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(94));
		rst      = 1'b1;
		in_valid = 1'b0;
		in_op    = pa_pkg::op_pass_a;
		in_src   = pa_pkg::src_lit;
		in_dst   = pa_pkg::dst_none;
		in_lit   = '0;
		m_ac     = '0;
		m_ar     = '0;
		m_ic     = '0;
		m_at     = '0;
		@(negedge clk);
		#2;
		if (in_ready !== 1'b0) begin
			$display("in_ready is high while reset is asserted");
			seq_errors++;
		end
		@(negedge clk);
		rst = 1'b0;

		zero_after_reset();
		load_registers();
		arith_flags();
		logic_ops();
		dependent_chain();
		random_stream();

		$display("tests passed %0d failed %0d, results checked %0d, errors %0d",
			tests_passed, tests_failed, rd_idx, errors + seq_errors);
		if (tests_failed == 0 && errors + seq_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* sim.f */
+incdir+sim
hdl/pa_pkg.sv
hdl/pa_stage_if.sv
hdl/pa_regs.sv
hdl/pa_fetch.sv
hdl/pa_alu.sv
hdl/pa_result.sv
hdl/pa_top.sv
sim/tb_pa.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_pa
FILELIST  = sim.f
BUILD     = obj_dir
LOG       = sim.log
FAIL_MSG  = TEST RESULT: FAIL
PASS_MSG  = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
